// File: run_sim.sh
#!/usr/bin/env bash
# Builds the queue testbench with Verilator and runs it.
# The run counts as passed only if the pass line shows up in the output.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f tb.f \
    --top-module tb_sed_protected_fifo -o sim_tb \
  && ./obj_dir/sim_tb | tee /dev/stderr | grep -qx "Testbench passed" \
  && echo "Simulation result: PASS" \
  || { echo "Simulation result: FAIL"; exit 1; }

// File: tb.f
+incdir+verilog
verilog/sed_pkg.sv
verilog/delay_valid.sv
verilog/ecc_sed_encoder.sv
verilog/sed_fifo_buffer.sv
verilog/ecc_sed_decoder.sv
verilog/sed_protected_fifo.sv
tb/sed_checker.sv
tb/tb_sed_protected_fifo.sv

// File: tb/sed_checker.sv
/* Watches the queue's ports, runs a reference queue model and compares every output.
   Exposes its error and event counts to the testbench top. */

`timescale 1ns/100ps
`default_nettype none

`include "sed_consts.svh"

module sed_checker (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              push,
  input  logic [`SED_DATA_WIDTH-1:0]        push_data,
  input  logic                              pop,
  input  logic [`SED_CODEWORD_WIDTH-1:0]    inject_mask,
  input  logic                              dec_valid,
  input  logic [`SED_DATA_WIDTH-1:0]        dec_data,
  input  logic                              dec_error,
  input  logic [`SED_ERR_COUNT_WIDTH-1:0]   err_count,
  input  logic                              overflow,
  input  logic                              underflow,
  input  logic [`SED_FIFO_DEPTH_LOG2:0]     level,
  output int                                value_errors,
  output int                                strobe_errors,
  output int                                words_checked,
  output int                                overflows_seen,
  output int                                underflows_seen
);

  localparam int DW       = `SED_DATA_WIDTH;
  localparam int CW       = `SED_CODEWORD_WIDTH;
  localparam int Depth    = `SED_FIFO_DEPTH;
  localparam int ErrLimit = (1 << `SED_ERR_COUNT_WIDTH) - 1;

  // Reference queue of accepted messages
  logic [DW-1:0] model_q [$];
  int            model_level;
  int            model_errs;

  // Pushes reach storage two cycles after the strobe
  logic          push_d1;
  logic          push_d2;
  logic [DW-1:0] data_d1;
  logic [DW-1:0] data_d2;

  // Expected decoder output for this cycle and the next
  logic          exp_dv_now;
  logic          exp_dv_next;
  logic [DW-1:0] exp_data_now;
  logic [DW-1:0] exp_data_next;
  logic          exp_err_now;
  logic          exp_err_next;
  logic          exp_ovf_now;
  logic          exp_udf_now;

  task automatic compare_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
    if (actual !== expected) begin
      $display("FAILED %s: expected 0x%0h, got 0x%0h at %0t", name, expected, actual, $time);
      value_errors++;
    end
  endtask

  task automatic compare_strobe(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
      $display("FAILED %s: expected 0x%0h, got 0x%0h at %0t", name, expected, actual, $time);
      strobe_errors++;
    end
  endtask

  // ----------------------------------------
  // Each edge samples the values of the cycle just ended
  // ----------------------------------------
  always @(posedge clk) begin : model_step
    logic          rd_acc;
    logic          wr_acc;
    logic [DW-1:0] head;
    logic [CW-1:0] flipped;
    if (rst) begin
      model_q.delete();
      model_level = 0;
      model_errs  = 0;
      push_d1     = 1'b0;
      push_d2     = 1'b0;
      exp_dv_now  = 1'b0;
      exp_dv_next = 1'b0;
      exp_ovf_now = 1'b0;
      exp_udf_now = 1'b0;
    end else begin
      // Compare the DUT against the model
      compare_strobe("dec_valid", dec_valid, exp_dv_now);
      if (dec_valid && exp_dv_now) begin
        compare_value("dec_data", 32'(dec_data), 32'(exp_data_now));
        compare_value("dec_error", 32'(dec_error), 32'(exp_err_now));
        words_checked++;
      end
      compare_strobe("overflow", overflow, exp_ovf_now);
      compare_strobe("underflow", underflow, exp_udf_now);
      compare_value("level", 32'(level), 32'(model_level));
      compare_value("err_count", 32'(err_count), 32'(model_errs));
      if (overflow === 1'b1) begin
        overflows_seen++;
      end
      if (underflow === 1'b1) begin
        underflows_seen++;
      end

      // Counter follows a failed word by one cycle and sticks at the top
      if (exp_dv_now && exp_err_now && model_errs < ErrLimit) begin
        model_errs++;
      end

      // Emptiness and fullness judged on this cycle's level
      rd_acc      = pop && (model_level != 0);
      wr_acc      = push_d2 && (model_level != Depth || pop);
      exp_ovf_now = push_d2 && !wr_acc;
      exp_udf_now = pop && (model_level == 0);

      exp_dv_now   = exp_dv_next;
      exp_data_now = exp_data_next;
      exp_err_now  = exp_err_next;
      exp_dv_next  = rd_acc;
      // Read goes first, so at full the old head leaves before the new word lands
      if (rd_acc) begin
        head          = model_q.pop_front();
        flipped       = {^head, head} ^ inject_mask;
        exp_data_next = flipped[DW-1:0];
        // Even parity exposes any odd number of flips
        exp_err_next  = ^flipped;
      end
      if (wr_acc) begin
        model_q.push_back(data_d2);
      end
      model_level = model_q.size();

      push_d2 = push_d1;
      data_d2 = data_d1;
      push_d1 = push;
      data_d1 = push_data;
    end
  end

endmodule

`default_nettype wire

// File: tb/tb_sed_protected_fifo.sv
/* Testbench top for the parity-protected queue: clock, reset, LFSR stimulus and watchdog.
   Clean traffic, an overflow burst, an underflow burst, then traffic with injected faults. */

`timescale 1ns/100ps
`default_nettype none

`include "sed_consts.svh"

module tb_sed_protected_fifo;

  // ----------------------------------------
  // Run length
  // ----------------------------------------
  localparam int DW = `SED_DATA_WIDTH;
  localparam int CW = `SED_CODEWORD_WIDTH;

  localparam int ResetCycles = 16;
  localparam int CleanCycles = 200;
  localparam int FillCycles  = 20;
  localparam int EmptyCycles = 20;
  // Long enough for the error counter to saturate
  localparam int FaultCycles = 1600;
  localparam int DrainCycles = 10;
  localparam int StimCycles  = ResetCycles + CleanCycles + FillCycles
                             + EmptyCycles + FaultCycles + DrainCycles;
  // Watchdog limit with margin for the pipeline tail
  localparam int TimeoutCycles = StimCycles * 3 / 2 + 50;

  logic                             clk;
  logic                             rst;
  logic                             push;
  logic [DW-1:0]                    push_data;
  logic                             pop;
  logic [CW-1:0]                    inject_mask;
  logic                             dec_valid;
  logic [DW-1:0]                    dec_data;
  logic                             dec_error;
  logic [`SED_ERR_COUNT_WIDTH-1:0]  err_count;
  logic                             overflow;
  logic                             underflow;
  logic [`SED_FIFO_DEPTH_LOG2:0]    level;

  int value_errors;
  int strobe_errors;
  int words_checked;
  int overflows_seen;
  int underflows_seen;
  int cycle_count = 0;

  // 16-bit Galois register seeded with 79
  logic [15:0] lfsr_state = 16'd79;

  // 20 ns period
  initial clk = 1'b0;
  always #10 clk = ~clk;

  // ----------------------------------------
  // Random source
  // ----------------------------------------

  // Taps for x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic [15:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 16'hB400;
    end
    return n;
  endfunction

  // One LFSR step per bit taken from the state's LSB
  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v          = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  // Exactly one or exactly two flipped bits anywhere in the codeword
  task automatic make_fault_mask(output logic [CW-1:0] mask);
    logic [31:0] r;
    int          first;
    int          second;
    take_bits(5, r);
    first = int'(r[4:0]) % CW;
    take_bits(4, r);
    // Offset 1..CW-1 keeps the second bit distinct
    second = (first + 1 + int'(r[3:0]) % (CW - 1)) % CW;
    mask = '0;
    mask[first] = 1'b1;
    take_bits(1, r);
    if (r[0]) begin
      mask[second] = 1'b1;
    end
  endtask

  // Inputs for one cycle change on the rising edge
  task automatic drive_cycle(input logic p, input logic [DW-1:0] d,
                             input logic q, input logic [CW-1:0] m);
    @(posedge clk);
    push        <= p;
    push_data   <= d;
    pop         <= q;
    inject_mask <= m;
  endtask

  // ----------------------------------------
  // DUT and checker
  // ----------------------------------------
  sed_protected_fifo u_sed_protected_fifo (
    .clk         (clk),
    .rst         (rst),
    .push        (push),
    .push_data   (push_data),
    .pop         (pop),
    .inject_mask (inject_mask),
    .dec_valid   (dec_valid),
    .dec_data    (dec_data),
    .dec_error   (dec_error),
    .err_count   (err_count),
    .overflow    (overflow),
    .underflow   (underflow),
    .level       (level)
  );

  sed_checker u_checker (
    .clk             (clk),
    .rst             (rst),
    .push            (push),
    .push_data       (push_data),
    .pop             (pop),
    .inject_mask     (inject_mask),
    .dec_valid       (dec_valid),
    .dec_data        (dec_data),
    .dec_error       (dec_error),
    .err_count       (err_count),
    .overflow        (overflow),
    .underflow       (underflow),
    .level           (level),
    .value_errors    (value_errors),
    .strobe_errors   (strobe_errors),
    .words_checked   (words_checked),
    .overflows_seen  (overflows_seen),
    .underflows_seen (underflows_seen)
  );

  // Watchdog
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TimeoutCycles) begin
      $display("Run timed out after %0d cycles without finishing the stimulus", cycle_count);
      $display("Testbench failed");
      $finish;
    end
  end

  // ----------------------------------------
  // Stimulus sequence
  // ----------------------------------------
  initial begin
    logic [31:0]   r_push;
    logic [31:0]   r_data;
    logic [31:0]   r_pop;
    logic [CW-1:0] mask;
    logic          coverage_ok;
    rst         <= 1'b1;
    push        <= 1'b0;
    push_data   <= '0;
    pop         <= 1'b0;
    inject_mask <= '0;
    repeat (ResetCycles) @(posedge clk);
    rst <= 1'b0;

    // Clean random traffic without faults
    for (int i = 0; i < CleanCycles; i++) begin
      take_bits(1, r_push);
      take_bits(DW, r_data);
      take_bits(1, r_pop);
      drive_cycle(r_push[0], r_data[DW-1:0], r_pop[0], '0);
    end

    // Pushes alone fill the buffer and force drops
    for (int i = 0; i < FillCycles; i++) begin
      take_bits(DW, r_data);
      drive_cycle(1'b1, r_data[DW-1:0], 1'b0, '0);
    end

    // Pops alone drain the buffer and run past empty
    for (int i = 0; i < EmptyCycles; i++) begin
      drive_cycle(1'b0, '0, 1'b1, '0);
    end

    // Random traffic with one- or two-bit read faults
    for (int i = 0; i < FaultCycles; i++) begin
      take_bits(1, r_push);
      take_bits(DW, r_data);
      take_bits(1, r_pop);
      make_fault_mask(mask);
      drive_cycle(r_push[0], r_data[DW-1:0], r_pop[0], mask);
    end

    // Idle while the last words leave the pipeline
    repeat (DrainCycles) drive_cycle(1'b0, '0, 1'b0, '0);
    @(negedge clk);

    coverage_ok = 1'b1;
    if (words_checked == 0) begin
      $display("No decoded word reached the output");
      coverage_ok = 1'b0;
    end
    if (overflows_seen == 0 || underflows_seen == 0) begin
      $display("The overflow or underflow case was never exercised");
      coverage_ok = 1'b0;
    end
    if (err_count !== '1) begin
      $display("The error counter never reached saturation");
      coverage_ok = 1'b0;
    end
    $display("Errors: %0d value, %0d strobe; %0d words, %0d overflows, %0d underflows",
             value_errors, strobe_errors, words_checked, overflows_seen, underflows_seen);
    if (value_errors == 0 && strobe_errors == 0 && coverage_ok) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/delay_valid.sv
/* Zero- or one-stage pipeline for a valid bit plus payload.
   Used for the optional input and output registers of the encoder and decoder. */

`timescale 1ns/100ps
`default_nettype none

module delay_valid #(
  parameter int Width     = 1,
  // Only 0 or 1 is supported
  parameter int NumStages = 0
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             in_valid,
  input  logic [Width-1:0] in,
  output logic             out_valid,
  output logic [Width-1:0] out
);

  generate
    if (NumStages == 0) begin : g_bypass

      // Straight through, no added latency
      assign out_valid = in_valid;
      assign out       = in;

    end else begin : g_stage

      logic             valid_q;
      logic [Width-1:0] data_q;

      // Valid is control state and clears on reset
      always_ff @(posedge clk) begin
        if (rst) begin
          valid_q <= 1'b0;
        end else begin
          valid_q <= in_valid;
        end
      end

      // Payload only loads alongside a valid beat
      always_ff @(posedge clk) begin
        if (in_valid) begin
          data_q <= in;
        end
      end

      assign out_valid = valid_q;
      assign out       = data_q;

    end
  endgenerate

endmodule

`default_nettype wire

// File: verilog/ecc_sed_decoder.sv
/* Even-parity checker: returns the message uncorrected, an error flag and a
   saturating count of failed words. Latency is RegisterInputs + RegisterOutputs. */

`timescale 1ns/100ps
`default_nettype none

`include "sed_consts.svh"

module ecc_sed_decoder #(
  // Register the codeword before the parity check
  parameter bit RegisterInputs  = 0,
  // Register message and error flag
  parameter bit RegisterOutputs = 0
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                cw_valid,
  input  sed_pkg::codeword_t  cw,
  output logic                dec_valid,
  output sed_pkg::data_t      dec_data,
  output logic                dec_error,
  output sed_pkg::err_count_t err_count
);

  import sed_pkg::*;

  logic      cw_valid_d;
  codeword_t cw_d;
  logic      syndrome;
  data_t     message;

  // ----------------------------------------
  // Input stage
  // ----------------------------------------
  delay_valid #(
    .Width     (`SED_CODEWORD_WIDTH),
    .NumStages (RegisterInputs ? 1 : 0)
  ) u_delay_in (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (cw_valid),
    .in        (cw),
    .out_valid (cw_valid_d),
    .out       (cw_d)
  );

  // ----------------------------------------
  // Parity check
  // ----------------------------------------

  // Odd number of ones anywhere in the codeword
  assign syndrome = ^cw_d;
  // No correction, message slice goes out as stored
  assign message  = cw_d[`SED_DATA_WIDTH-1:0];

  // Flag rides in the MSB next to the message
  delay_valid #(
    .Width     (`SED_DATA_WIDTH + 1),
    .NumStages (RegisterOutputs ? 1 : 0)
  ) u_delay_out (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (cw_valid_d),
    .in        ({syndrome, message}),
    .out_valid (dec_valid),
    .out       ({dec_error, dec_data})
  );

  // ----------------------------------------
  // Error counter
  // ----------------------------------------

  // Sticks at all ones
  always_ff @(posedge clk) begin
    if (rst) begin
      err_count <= '0;
    end else if (dec_valid && dec_error && (err_count != '1)) begin
      err_count <= err_count + 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: verilog/ecc_sed_encoder.sv
/* Even-parity single-error-detecting encoder producing {parity, message}.
   Latency is RegisterInputs + RegisterOutputs cycles. */

`timescale 1ns/100ps
`default_nettype none

`include "sed_consts.svh"

module ecc_sed_encoder #(
  // Register the incoming word before the parity tree
  parameter bit RegisterInputs  = 0,
  // Register the finished codeword
  parameter bit RegisterOutputs = 0
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               data_valid,
  input  sed_pkg::data_t     data,
  output logic               enc_valid,
  output sed_pkg::codeword_t enc_codeword
);

  import sed_pkg::*;

  logic      data_valid_d;
  data_t     data_d;
  logic      parity;
  codeword_t codeword;

  // ----------------------------------------
  // Input stage
  // ----------------------------------------
  delay_valid #(
    .Width     (`SED_DATA_WIDTH),
    .NumStages (RegisterInputs ? 1 : 0)
  ) u_delay_in (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (data_valid),
    .in        (data),
    .out_valid (data_valid_d),
    .out       (data_d)
  );

  // ----------------------------------------
  // Parity generation
  // ----------------------------------------

  // XOR of the message makes the total count of ones even
  assign parity   = ^data_d;
  // Systematic form, parity above the message bits
  assign codeword = {parity, data_d};

  // ----------------------------------------
  // Output stage
  // ----------------------------------------
  delay_valid #(
    .Width     (`SED_CODEWORD_WIDTH),
    .NumStages (RegisterOutputs ? 1 : 0)
  ) u_delay_out (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (data_valid_d),
    .in        (codeword),
    .out_valid (enc_valid),
    .out       (enc_codeword)
  );

endmodule

`default_nettype wire

// File: verilog/sed_consts.svh
/* Sizing constants for the parity-protected queue.
   Included by the package, the RTL and the testbench so every width stays in step. */

`ifndef SED_CONSTS_SVH
`define SED_CONSTS_SVH

// ----------------------------------------
// Message and code geometry
// ----------------------------------------

// Message bits per word
`define SED_DATA_WIDTH 16

// Single even-parity bit on top of the message
`define SED_PARITY_WIDTH 1

// Full codeword, parity in the MSBs
`define SED_CODEWORD_WIDTH (`SED_DATA_WIDTH + `SED_PARITY_WIDTH)

// ----------------------------------------
// Storage and status
// ----------------------------------------

// Eight entries in the buffer
`define SED_FIFO_DEPTH_LOG2 3
`define SED_FIFO_DEPTH (1 << `SED_FIFO_DEPTH_LOG2)

// Saturating error counter, tops out at 255
`define SED_ERR_COUNT_WIDTH 8

`endif

// File: verilog/sed_fifo_buffer.sv
/* Eight-entry circular codeword queue driven by push and pop strobes.
   Reports dropped pushes and empty pops, and XORs a fault mask onto the read path. */

`timescale 1ns/100ps
`default_nettype none

`include "sed_consts.svh"

module sed_fifo_buffer (
  input  logic               clk,
  input  logic               rst,
  input  logic               wr_valid,
  input  sed_pkg::codeword_t wr_codeword,
  input  logic               pop,
  input  sed_pkg::codeword_t inject_mask,
  output logic               rd_valid,
  output sed_pkg::codeword_t rd_codeword,
  output sed_pkg::level_t    level,
  output logic               overflow,
  output logic               underflow
);

  import sed_pkg::*;

  // Storage array, contents are don't-care after reset
  codeword_t mem [`SED_FIFO_DEPTH];

  logic [`SED_FIFO_DEPTH_LOG2-1:0] wr_ptr;
  logic [`SED_FIFO_DEPTH_LOG2-1:0] rd_ptr;

  logic full;
  logic empty;
  logic wr_accept;
  logic rd_accept;

  // ----------------------------------------
  // Full / empty decisions
  // ----------------------------------------

  // Judged on the level as it stands this cycle
  assign full  = (level == level_t'(`SED_FIFO_DEPTH));
  assign empty = (level == '0);

  // A pop at full frees a slot for the write in the same cycle
  assign wr_accept = wr_valid && (!full || pop);
  assign rd_accept = pop && !empty;

  // ----------------------------------------
  // Pointers, level and status strobes
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      level     <= '0;
      rd_valid  <= 1'b0;
      overflow  <= 1'b0;
      underflow <= 1'b0;
    end else begin
      // Pointers wrap on their own, depth is a power of two
      if (wr_accept) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_accept) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // Net change of occupancy
      if (wr_accept && !rd_accept) begin
        level <= level + 1'b1;
      end else if (rd_accept && !wr_accept) begin
        level <= level - 1'b1;
      end
      rd_valid  <= rd_accept;
      // Pulse one cycle after the offending strobe
      overflow  <= wr_valid && !wr_accept;
      underflow <= pop && empty;
    end
  end

  // ----------------------------------------
  // Storage write and faulty read path
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (wr_accept) begin
      mem[wr_ptr] <= wr_codeword;
    end
  end

  // Old entry is read even when written at the same address at full
  always_ff @(posedge clk) begin
    if (rd_accept) begin
      rd_codeword <= mem[rd_ptr] ^ inject_mask;
    end
  end

endmodule

`default_nettype wire

// File: verilog/sed_pkg.sv
/* Shared types for the parity-protected queue, sized from the constants header.
   Modules name these types with sed_pkg:: in ports and import the package in the body. */

`default_nettype none

`include "sed_consts.svh"

package sed_pkg;

  // ----------------------------------------
  // Payload types
  // ----------------------------------------

  // One message as pushed by the user
  typedef logic [`SED_DATA_WIDTH-1:0] data_t;

  // Stored form: {parity, message}
  typedef logic [`SED_CODEWORD_WIDTH-1:0] codeword_t;

  // ----------------------------------------
  // Status types
  // ----------------------------------------

  // Occupancy 0..8, one bit wider than the pointers
  typedef logic [`SED_FIFO_DEPTH_LOG2:0] level_t;

  // Count of words that failed the parity check
  typedef logic [`SED_ERR_COUNT_WIDTH-1:0] err_count_t;

endpackage

`default_nettype wire

// File: verilog/sed_protected_fifo.sv
/* Top level of the parity-protected queue: encoder, buffer and decoder in a row.
   Push reaches storage after two cycles, a pop shows up at the output after two. */

`timescale 1ns/100ps
`default_nettype none

`include "sed_consts.svh"

module sed_protected_fifo (
  input  logic                              clk,
  input  logic                              rst,
  // Write side
  input  logic                              push,
  input  logic [`SED_DATA_WIDTH-1:0]        push_data,
  // Read side
  input  logic                              pop,
  input  logic [`SED_CODEWORD_WIDTH-1:0]    inject_mask,
  output logic                              dec_valid,
  output logic [`SED_DATA_WIDTH-1:0]        dec_data,
  output logic                              dec_error,
  // Status
  output logic [`SED_ERR_COUNT_WIDTH-1:0]   err_count,
  output logic                              overflow,
  output logic                              underflow,
  output logic [`SED_FIFO_DEPTH_LOG2:0]     level
);

  import sed_pkg::*;

  logic      enc_valid;
  codeword_t enc_codeword;
  logic      rd_valid;
  codeword_t rd_codeword;

  // ----------------------------------------
  // Encode, two register stages
  // ----------------------------------------
  ecc_sed_encoder #(
    .RegisterInputs  (1'b1),
    .RegisterOutputs (1'b1)
  ) u_encoder (
    .clk          (clk),
    .rst          (rst),
    .data_valid   (push),
    .data         (push_data),
    .enc_valid    (enc_valid),
    .enc_codeword (enc_codeword)
  );

  // ----------------------------------------
  // Storage with fault injection on read
  // ----------------------------------------
  sed_fifo_buffer u_buffer (
    .clk         (clk),
    .rst         (rst),
    .wr_valid    (enc_valid),
    .wr_codeword (enc_codeword),
    .pop         (pop),
    .inject_mask (inject_mask),
    .rd_valid    (rd_valid),
    .rd_codeword (rd_codeword),
    .level       (level),
    .overflow    (overflow),
    .underflow   (underflow)
  );

  // ----------------------------------------
  // Check, registered outputs only
  // ----------------------------------------
  ecc_sed_decoder #(
    .RegisterInputs  (1'b0),
    .RegisterOutputs (1'b1)
  ) u_decoder (
    .clk       (clk),
    .rst       (rst),
    .cw_valid  (rd_valid),
    .cw        (rd_codeword),
    .dec_valid (dec_valid),
    .dec_data  (dec_data),
    .dec_error (dec_error),
    .err_count (err_count)
  );

endmodule

`default_nettype wire
